// File: execUnit.f
verilog/exePkg.sv
verilog/aluStage.sv
verilog/exeMemRegister.sv
verilog/memoryRequest.sv
verilog/executionUnit.sv
verification/tbClock.sv
verification/executionUnitTb.sv

// File: run.sh
#!/bin/sh
# build and run the execution unit testbench with Verilator

verilator --binary --timing --assert --top-module executionUnitTb \
  -f execUnit.f -o simExecUnit || { echo "build failed"; exit 1; }

./obj_dir/simExecUnit > sim.log 2>&1
cat sim.log

grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation did not complete"; exit 1; }
exit 0

// File: verification/executionUnitTb.sv
`timescale 1ns/100ps

module executionUnitTb;

  localparam int timeoutCycles = 2000;

  logic                            clock;
  logic                            rstN;
  logic [exePkg::dataWidth-1:0]    operandA, operandB, storeDataIn;
  logic [exePkg::dataWidth-1:0]    forwardedOperandA, forwardedOperandB, forwardedStoreData;
  logic                            useForwardedOpA, useForwardedOpB, useForwardedStoreData;
  logic                            protectRegA, protectRegB;
  exePkg::aluOpT                   aluOp;
  exePkg::resultSelT               resultSelection;
  logic [exePkg::regAddrWidth-1:0] destination, writeAddress;
  logic                            weDestination, stall, flush, resetLoad;
  exePkg::loadKindT                load, memoryLoad;
  exePkg::storeKindT               store, memoryStore;
  logic [exePkg::dataWidth-1:0]    writeData, memoryAddress, dataOut;
  logic                            writeEnable, flagOut, weFlag, alignmentError;
  int                              cycleCount;

  exePkg::aluOpT     aluOps [12] = '{exePkg::opAdd, exePkg::opSub, exePkg::opAnd, exePkg::opOr,
                                     exePkg::opXor, exePkg::opSll, exePkg::opSrl, exePkg::opSra,
                                     exePkg::opSetEq, exePkg::opSetNe, exePkg::opSetLtu,
                                     exePkg::opSetLts};
  exePkg::loadKindT  loadKinds [6] = '{exePkg::loadByteZero, exePkg::loadByteSign,
                                       exePkg::loadHalfZero, exePkg::loadHalfSign,
                                       exePkg::loadWordZero, exePkg::loadWordSign};
  exePkg::storeKindT storeKinds [4] = '{exePkg::storeByte, exePkg::storeHalf,
                                        exePkg::storeWord, exePkg::storeSwap};

  tbClock clockGen0 (.clock(clock), .rstN(rstN));

  executionUnit dut0 (.*);

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Error at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // inputs change 2 ns after the edge and outputs are read there too
  task automatic stepCycle();
    @(posedge clock);
    #2;
  endtask

  task automatic setIdle();
    operandA = '0;
    operandB = '0;
    storeDataIn = '0;
    forwardedOperandA = '0;
    forwardedOperandB = '0;
    forwardedStoreData = '0;
    useForwardedOpA = 1'b0;
    useForwardedOpB = 1'b0;
    useForwardedStoreData = 1'b0;
    protectRegA = 1'b0;
    protectRegB = 1'b0;
    aluOp = exePkg::opAdd;
    resultSelection = exePkg::resAdder;
    destination = '0;
    weDestination = 1'b0;
    load = exePkg::noLoad;
    store = exePkg::noStore;
    stall = 1'b0;
    flush = 1'b0;
    resetLoad = 1'b0;
  endtask

  task automatic driveAlu(input exePkg::aluOpT op, input exePkg::resultSelT sel,
                          input logic [31:0] a, input logic [31:0] b);
    aluOp = op;
    resultSelection = sel;
    operandA = a;
    operandB = b;
  endtask

  function automatic exePkg::resultSelT naturalSelection(input exePkg::aluOpT op);
    case (op)
      exePkg::opAnd, exePkg::opOr, exePkg::opXor: return exePkg::resLogic;
      exePkg::opSll, exePkg::opSrl, exePkg::opSra: return exePkg::resShift;
      default: return exePkg::resAdder;
    endcase
  endfunction

  function automatic logic [31:0] expectedResult(input exePkg::aluOpT op,
                                                 input exePkg::resultSelT sel,
                                                 input logic [31:0] a, input logic [31:0] b);
    logic [31:0] value;
    case (sel)
      exePkg::resMove: value = b;
      exePkg::resLogic: value = (op == exePkg::opAnd) ? (a & b) :
                                (op == exePkg::opOr) ? (a | b) : (a ^ b);
      exePkg::resShift:
        if (op == exePkg::opSra)
          value = $signed(a) >>> b[4:0];
        else
          value = (op == exePkg::opSrl) ? (a >> b[4:0]) : (a << b[4:0]);
      default: value = (op == exePkg::opAdd) ? (a + b) : (a - b);
    endcase
    return value;
  endfunction

  function automatic logic expectedFlag(input exePkg::aluOpT op, input logic [31:0] a,
                                        input logic [31:0] b);
    case (op)
      exePkg::opSetEq:  return a == b;
      exePkg::opSetNe:  return a != b;
      exePkg::opSetLtu: return a < b;
      exePkg::opSetLts: return $signed(a) < $signed(b);
      default:          return 1'b0;
    endcase
  endfunction

  // bytes per access or zero without a memory operation
  function automatic int accessSize(input exePkg::loadKindT ld, input exePkg::storeKindT st);
    case (ld)
      exePkg::loadByteZero, exePkg::loadByteSign: return 1;
      exePkg::loadHalfZero, exePkg::loadHalfSign: return 2;
      exePkg::loadWordZero, exePkg::loadWordSign: return 4;
      default:
        case (st)
          exePkg::storeByte: return 1;
          exePkg::storeHalf: return 2;
          exePkg::storeWord, exePkg::storeSwap: return 4;
          default: return 0;
        endcase
    endcase
  endfunction

  task automatic checkReset();
    checkValue("writeEnable", 32'd0, 32'(writeEnable));
    checkValue("weFlag", 32'd0, 32'(weFlag));
    checkValue("alignmentError", 32'd0, 32'(alignmentError));
    checkValue("memoryLoad", 32'(exePkg::noLoad), 32'(memoryLoad));
    checkValue("memoryStore", 32'(exePkg::noStore), 32'(memoryStore));
  endtask

  task automatic checkAluOps();
    exePkg::resultSelT sel;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [4:0]        dest;
    for (int i = 0; i < 12; i++)
    begin
      for (int n = 0; n < 4; n++)
      begin
        // last pass of each op moves operand B instead
        if (n == 3)
          sel = exePkg::resMove;
        else
          sel = naturalSelection(aluOps[i]);
        a = $urandom;
        b = $urandom;
        dest = 5'($urandom);
        driveAlu(aluOps[i], sel, a, b);
        destination = dest;
        weDestination = 1'b1;
        stepCycle();
        checkValue("writeData", expectedResult(aluOps[i], sel, a, b), writeData);
        checkValue("writeAddress", 32'(dest), 32'(writeAddress));
        checkValue("writeEnable", 32'd1, 32'(writeEnable));
      end
    end
    setIdle();
  endtask

  task automatic checkForwarding();
    logic [31:0] expA;
    logic [31:0] expB;
    logic [31:0] expStore;
    for (int i = 0; i < 16; i++)
    begin
      driveAlu(exePkg::opSub, exePkg::resAdder, $urandom, $urandom);
      forwardedOperandA = $urandom;
      forwardedOperandB = $urandom;
      storeDataIn = $urandom;
      forwardedStoreData = $urandom;
      useForwardedOpA = i[0];
      protectRegA = i[1];
      useForwardedOpB = i[2];
      protectRegB = i[3];
      useForwardedStoreData = i[0] ^ i[2];
      store = exePkg::storeByte;
      expA = (i[0] && !i[1]) ? forwardedOperandA : operandA;
      expB = (i[2] && !i[3]) ? forwardedOperandB : operandB;
      expStore = useForwardedStoreData ? forwardedStoreData : storeDataIn;
      stepCycle();
      checkValue("writeData", expA - expB, writeData);
      checkValue("dataOut", expStore, dataOut);
    end
    setIdle();
  endtask

  task automatic checkCompares();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 8; i < 12; i++)
    begin
      for (int n = 0; n < 6; n++)
      begin
        a = $urandom;
        if (n < 2)
          b = a;
        else if (n == 2)
          b = a ^ 32'h8000_0000;
        else
          b = $urandom;
        driveAlu(aluOps[i], exePkg::resAdder, a, b);
        stepCycle();
        checkValue("flagOut", 32'(expectedFlag(aluOps[i], a, b)), 32'(flagOut));
        checkValue("weFlag", 32'd1, 32'(weFlag));
        checkValue("writeData", a - b, writeData);
      end
    end
    driveAlu(exePkg::opXor, exePkg::resLogic, $urandom, $urandom);
    stepCycle();
    checkValue("weFlag", 32'd0, 32'(weFlag));
    setIdle();
  endtask

  task automatic checkStallFlush();
    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  dest;
    a = $urandom & 32'hffff_fffc;
    b = $urandom & 32'hffff_fffc;
    dest = 5'($urandom);
    driveAlu(exePkg::opAdd, exePkg::resAdder, a, b);
    destination = dest;
    weDestination = 1'b1;
    load = exePkg::loadWordSign;
    stepCycle();
    // a different item waits at the inputs while stalled
    stall = 1'b1;
    driveAlu(exePkg::opSetEq, exePkg::resMove, $urandom, $urandom);
    destination = ~dest;
    load = exePkg::loadByteZero;
    store = exePkg::storeByte;
    repeat (3)
    begin
      stepCycle();
      checkValue("writeData", a + b, writeData);
      checkValue("writeAddress", 32'(dest), 32'(writeAddress));
      checkValue("writeEnable", 32'd1, 32'(writeEnable));
      checkValue("weFlag", 32'd0, 32'(weFlag));
      checkValue("memoryAddress", a + b, memoryAddress);
      checkValue("memoryLoad", 32'(exePkg::loadWordSign), 32'(memoryLoad));
      checkValue("memoryStore", 32'(exePkg::noStore), 32'(memoryStore));
    end
    stall = 1'b0;
    flush = 1'b1;
    stepCycle();
    checkValue("writeEnable", 32'd0, 32'(writeEnable));
    checkValue("weFlag", 32'd0, 32'(weFlag));
    checkValue("memoryLoad", 32'(exePkg::noLoad), 32'(memoryLoad));
    checkValue("memoryStore", 32'(exePkg::noStore), 32'(memoryStore));
    flush = 1'b0;
    a = $urandom & 32'hffff_fffc;
    b = $urandom & 32'hffff_fffc;
    driveAlu(exePkg::opAdd, exePkg::resAdder, a, b);
    load = exePkg::noLoad;
    store = exePkg::storeHalf;
    stepCycle();
    checkValue("memoryStore", 32'(exePkg::storeHalf), 32'(memoryStore));
    stall = 1'b1;
    resetLoad = 1'b1;
    // changed inputs would show up if the stall let them through
    weDestination = 1'b0;
    operandA = ~a;
    stepCycle();
    checkValue("memoryStore", 32'(exePkg::noStore), 32'(memoryStore));
    checkValue("memoryLoad", 32'(exePkg::noLoad), 32'(memoryLoad));
    checkValue("writeEnable", 32'd1, 32'(writeEnable));
    checkValue("memoryAddress", a + b, memoryAddress);
    setIdle();
  endtask

  task automatic checkMemoryAccess();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expAddress;
    logic        misaligned;
    int          size;
    for (int i = 0; i < 10; i++)
    begin
      for (int off = 0; off < 4; off++)
      begin
        a = $urandom & 32'hffff_fffc;
        b = ($urandom & 32'hffff_fffc) | off;
        load = (i < 6) ? loadKinds[i] : exePkg::noLoad;
        store = (i < 6) ? exePkg::noStore : storeKinds[i - 6];
        // swap takes its address straight from operand A
        if (store == exePkg::storeSwap)
        begin
          a = a | off;
          expAddress = a;
        end
        else
          expAddress = a + b;
        size = accessSize(load, store);
        misaligned = (size == 4 && off != 0) || (size == 2 && off[0]);
        driveAlu(exePkg::opAdd, exePkg::resAdder, a, b);
        stepCycle();
        checkValue("memoryAddress", expAddress, memoryAddress);
        checkValue("alignmentError", 32'(misaligned), 32'(alignmentError));
        checkValue("memoryLoad", misaligned ? 32'(exePkg::noLoad) : 32'(load),
                   32'(memoryLoad));
        checkValue("memoryStore", misaligned ? 32'(exePkg::noStore) : 32'(store),
                   32'(memoryStore));
      end
    end
    setIdle();
  endtask

  initial
  begin
    cycleCount = 0;
    while (cycleCount < timeoutCycles)
    begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

  initial
  begin
    void'($urandom(32'hd103));
    setIdle();
    @(posedge rstN);
    checkReset();
    stepCycle();
    checkAluOps();
    checkForwarding();
    checkCompares();
    checkStallFlush();
    checkMemoryAccess();
    $display("TEST PASS");
    $finish;
  end

endmodule

// File: verification/tbClock.sv
`timescale 1ns/100ps

module tbClock
(
  output logic clock,
  output logic rstN
);

  initial
  begin
    clock = 1'b0;
    rstN  = 1'b0;
    repeat (5) @(posedge clock);
    #2 rstN = 1'b1;
  end

  always #10 clock = ~clock;

endmodule

// File: verilog/executionUnit.sv
`timescale 1ns/100ps

module executionUnit
(
  input  logic                            clock,
  input  logic                            rstN,
  input  logic [exePkg::dataWidth-1:0]    operandA,
  input  logic [exePkg::dataWidth-1:0]    operandB,
  input  logic [exePkg::dataWidth-1:0]    storeDataIn,
  input  logic [exePkg::dataWidth-1:0]    forwardedOperandA,
  input  logic [exePkg::dataWidth-1:0]    forwardedOperandB,
  input  logic [exePkg::dataWidth-1:0]    forwardedStoreData,
  input  logic                            useForwardedOpA,
  input  logic                            useForwardedOpB,
  input  logic                            useForwardedStoreData,
  input  logic                            protectRegA,
  input  logic                            protectRegB,
  input  exePkg::aluOpT                   aluOp,
  input  exePkg::resultSelT               resultSelection,
  input  logic [exePkg::regAddrWidth-1:0] destination,
  input  logic                            weDestination,
  input  exePkg::loadKindT                load,
  input  exePkg::storeKindT               store,
  input  logic                            stall,
  input  logic                            flush,
  input  logic                            resetLoad,
  output logic [exePkg::dataWidth-1:0]    writeData,
  output logic [exePkg::regAddrWidth-1:0] writeAddress,
  output logic                            writeEnable,
  output logic                            flagOut,
  output logic                            weFlag,
  output logic [exePkg::dataWidth-1:0]    memoryAddress,
  output logic [exePkg::dataWidth-1:0]    dataOut,
  output exePkg::loadKindT                memoryLoad,
  output exePkg::storeKindT               memoryStore,
  output logic                            alignmentError
);

  logic [exePkg::dataWidth-1:0] resultNext;
  logic                         flagNext;
  logic                         isCompare;
  logic [exePkg::dataWidth-1:0] addressNext;
  logic                         addressValid;
  logic [exePkg::dataWidth-1:0] storeDataNext;
  exePkg::loadKindT             loadReg;
  exePkg::storeKindT            storeReg;

  aluStage alu0
  (
    .operandA(operandA),
    .operandB(operandB),
    .storeDataIn(storeDataIn),
    .forwardedOperandA(forwardedOperandA),
    .forwardedOperandB(forwardedOperandB),
    .forwardedStoreData(forwardedStoreData),
    .useForwardedOpA(useForwardedOpA),
    .useForwardedOpB(useForwardedOpB),
    .useForwardedStoreData(useForwardedStoreData),
    .protectRegA(protectRegA),
    .protectRegB(protectRegB),
    .aluOp(aluOp),
    .resultSelection(resultSelection),
    .load(load),
    .store(store),
    .resultNext(resultNext),
    .flagNext(flagNext),
    .isCompare(isCompare),
    .addressNext(addressNext),
    .addressValid(addressValid),
    .storeDataNext(storeDataNext)
  );

  exeMemRegister exeMem0
  (
    .clock(clock),
    .rstN(rstN),
    .stall(stall),
    .flush(flush),
    .resetLoad(resetLoad),
    .resultNext(resultNext),
    .flagNext(flagNext),
    .isCompare(isCompare),
    .addressNext(addressNext),
    .addressValid(addressValid),
    .storeDataNext(storeDataNext),
    .destination(destination),
    .weDestination(weDestination),
    .load(load),
    .store(store),
    .writeData(writeData),
    .writeAddress(writeAddress),
    .writeEnable(writeEnable),
    .flagOut(flagOut),
    .weFlag(weFlag),
    .memoryAddress(memoryAddress),
    .dataOut(dataOut),
    .loadReg(loadReg),
    .storeReg(storeReg)
  );

  memoryRequest memReq0
  (
    .memoryAddress(memoryAddress),
    .loadReg(loadReg),
    .storeReg(storeReg),
    .memoryLoad(memoryLoad),
    .memoryStore(memoryStore),
    .alignmentError(alignmentError)
  );

endmodule

// File: verilog/memoryRequest.sv
`timescale 1ns/100ps

module memoryRequest
(
  input  logic [exePkg::dataWidth-1:0] memoryAddress,
  input  exePkg::loadKindT             loadReg,
  input  exePkg::storeKindT            storeReg,
  output exePkg::loadKindT             memoryLoad,
  output exePkg::storeKindT            memoryStore,
  output logic                         alignmentError
);

  logic wordAccess;
  logic halfAccess;

  assign wordAccess = (loadReg == exePkg::loadWordZero) ||
                      (loadReg == exePkg::loadWordSign) ||
                      (storeReg == exePkg::storeWord) ||
                      (storeReg == exePkg::storeSwap);

  assign halfAccess = (loadReg == exePkg::loadHalfZero) ||
                      (loadReg == exePkg::loadHalfSign) ||
                      (storeReg == exePkg::storeHalf);

  assign alignmentError = (wordAccess && (memoryAddress[1:0] != 2'b00)) ||
                          (halfAccess && memoryAddress[0]);

  // the cache never sees a misaligned request
  assign memoryLoad  = alignmentError ? exePkg::noLoad : loadReg;
  assign memoryStore = alignmentError ? exePkg::noStore : storeReg;

endmodule

// File: verilog/exeMemRegister.sv
`timescale 1ns/100ps

module exeMemRegister
(
  input  logic                            clock,
  input  logic                            rstN,
  input  logic                            stall,
  input  logic                            flush,
  input  logic                            resetLoad,
  input  logic [exePkg::dataWidth-1:0]    resultNext,
  input  logic                            flagNext,
  input  logic                            isCompare,
  input  logic [exePkg::dataWidth-1:0]    addressNext,
  input  logic                            addressValid,
  input  logic [exePkg::dataWidth-1:0]    storeDataNext,
  input  logic [exePkg::regAddrWidth-1:0] destination,
  input  logic                            weDestination,
  input  exePkg::loadKindT                load,
  input  exePkg::storeKindT               store,
  output logic [exePkg::dataWidth-1:0]    writeData,
  output logic [exePkg::regAddrWidth-1:0] writeAddress,
  output logic                            writeEnable,
  output logic                            flagOut,
  output logic                            weFlag,
  output logic [exePkg::dataWidth-1:0]    memoryAddress,
  output logic [exePkg::dataWidth-1:0]    dataOut,
  output exePkg::loadKindT                loadReg,
  output exePkg::storeKindT               storeReg
);

  // write-back control
  always_ff @(posedge clock)
  begin
    if (!rstN)
    begin
      writeEnable <= 1'b0;
      weFlag      <= 1'b0;
    end
    else if (!stall)
    begin
      writeEnable <= weDestination & ~flush;
      weFlag      <= isCompare & ~flush;
    end
  end

  // resetLoad cancels the memory request even while stalled
  always_ff @(posedge clock)
  begin
    if (!rstN || resetLoad)
    begin
      loadReg  <= exePkg::noLoad;
      storeReg <= exePkg::noStore;
    end
    else if (!stall)
    begin
      if (flush)
      begin
        loadReg  <= exePkg::noLoad;
        storeReg <= exePkg::noStore;
      end
      else
      begin
        loadReg  <= load;
        storeReg <= store;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (!stall)
    begin
      writeData    <= resultNext;
      writeAddress <= destination;
      flagOut      <= flagNext;
    end
  end

  // address and store data only move for a memory operation
  always_ff @(posedge clock)
  begin
    if (!stall && addressValid)
    begin
      memoryAddress <= addressNext;
      dataOut       <= storeDataNext;
    end
  end

  property stallHolds;
    @(posedge clock)
      rstN && stall |=> $stable(writeData) && $stable(writeAddress) &&
        $stable(writeEnable) && $stable(flagOut) && $stable(weFlag) &&
        $stable(memoryAddress) && $stable(dataOut) &&
        ($past(resetLoad) || ($stable(loadReg) && $stable(storeReg)));
  endproperty

  assert property (stallHolds)
  else $error("pipeline register changed during stall");

  assert property (@(posedge clock) !rstN |=> !writeEnable && !weFlag)
  else $error("write enables active after reset");

endmodule

// File: verilog/aluStage.sv
`timescale 1ns/100ps

module aluStage
(
  input  logic [exePkg::dataWidth-1:0] operandA,
  input  logic [exePkg::dataWidth-1:0] operandB,
  input  logic [exePkg::dataWidth-1:0] storeDataIn,
  input  logic [exePkg::dataWidth-1:0] forwardedOperandA,
  input  logic [exePkg::dataWidth-1:0] forwardedOperandB,
  input  logic [exePkg::dataWidth-1:0] forwardedStoreData,
  input  logic                         useForwardedOpA,
  input  logic                         useForwardedOpB,
  input  logic                         useForwardedStoreData,
  input  logic                         protectRegA,
  input  logic                         protectRegB,
  input  exePkg::aluOpT                aluOp,
  input  exePkg::resultSelT            resultSelection,
  input  exePkg::loadKindT             load,
  input  exePkg::storeKindT            store,
  output logic [exePkg::dataWidth-1:0] resultNext,
  output logic                         flagNext,
  output logic                         isCompare,
  output logic [exePkg::dataWidth-1:0] addressNext,
  output logic                         addressValid,
  output logic [exePkg::dataWidth-1:0] storeDataNext
);

  logic [exePkg::dataWidth-1:0] opA;
  logic [exePkg::dataWidth-1:0] opB;
  logic [exePkg::dataWidth-1:0] adderSum;
  logic [exePkg::dataWidth-1:0] logicResult;
  logic [exePkg::dataWidth-1:0] shiftResult;
  logic [4:0]                   shiftAmount;
  logic                         subtract;
  logic                         lessUnsigned;
  logic                         lessSigned;

  // a protected register ignores the forward path
  assign opA = (useForwardedOpA && !protectRegA) ? forwardedOperandA : operandA;
  assign opB = (useForwardedOpB && !protectRegB) ? forwardedOperandB : operandB;
  assign storeDataNext = useForwardedStoreData ? forwardedStoreData : storeDataIn;

  always_comb
  begin
    case (aluOp)
      exePkg::opSetEq, exePkg::opSetNe, exePkg::opSetLtu, exePkg::opSetLts:
        isCompare = 1'b1;
      default:
        isCompare = 1'b0;
    endcase
  end

  assign subtract = (aluOp == exePkg::opSub) || isCompare;
  assign adderSum = opA + (subtract ? ~opB : opB) + exePkg::dataWidth'(subtract);

  // compares come from the difference sign and need no carry
  assign lessUnsigned = (opA[31] != opB[31]) ? opB[31] : adderSum[31];
  assign lessSigned   = (opA[31] != opB[31]) ? opA[31] : adderSum[31];

  always_comb
  begin
    case (aluOp)
      exePkg::opSetEq:  flagNext = (adderSum == '0);
      exePkg::opSetNe:  flagNext = (adderSum != '0);
      exePkg::opSetLtu: flagNext = lessUnsigned;
      exePkg::opSetLts: flagNext = lessSigned;
      default:          flagNext = 1'b0;
    endcase
  end

  always_comb
  begin
    case (aluOp)
      exePkg::opAnd: logicResult = opA & opB;
      exePkg::opOr:  logicResult = opA | opB;
      default:       logicResult = opA ^ opB;
    endcase
  end

  assign shiftAmount = opB[4:0];

  always_comb
  begin
    case (aluOp)
      exePkg::opSrl: shiftResult = opA >> shiftAmount;
      exePkg::opSra: shiftResult = $signed(opA) >>> shiftAmount;
      default:       shiftResult = opA << shiftAmount;
    endcase
  end

  always_comb
  begin
    case (resultSelection)
      exePkg::resLogic: resultNext = logicResult;
      exePkg::resShift: resultNext = shiftResult;
      exePkg::resMove:  resultNext = opB;
      default:          resultNext = adderSum;
    endcase
  end

  // swap addresses memory through operand A directly
  assign addressNext  = (store == exePkg::storeSwap) ? opA : adderSum;
  assign addressValid = (load != exePkg::noLoad) || (store != exePkg::noStore);

endmodule

// File: verilog/exePkg.sv
package exePkg;

  // one machine word and one register index
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;

  typedef enum logic [3:0]
  {
    opAdd    = 4'd0,
    opSub    = 4'd1,
    opAnd    = 4'd2,
    opOr     = 4'd3,
    opXor    = 4'd4,
    opSll    = 4'd5,
    opSrl    = 4'd6,
    opSra    = 4'd7,
    opSetEq  = 4'd8,
    opSetNe  = 4'd9,
    opSetLtu = 4'd10,
    opSetLts = 4'd11
  } aluOpT;

  // write-back source
  typedef enum logic [1:0]
  {
    resAdder = 2'd0,
    resLogic = 2'd1,
    resShift = 2'd2,
    resMove  = 2'd3
  } resultSelT;

  // bit 2 selects sign extension, bits 1:0 give the size
  typedef enum logic [2:0]
  {
    noLoad       = 3'b000,
    loadByteZero = 3'b001,
    loadByteSign = 3'b101,
    loadHalfZero = 3'b010,
    loadHalfSign = 3'b110,
    loadWordZero = 3'b011,
    loadWordSign = 3'b111
  } loadKindT;

  typedef enum logic [2:0]
  {
    noStore   = 3'b000,
    storeByte = 3'b001,
    storeHalf = 3'b010,
    storeWord = 3'b011,
    storeSwap = 3'b101
  } storeKindT;

endpackage
